// ==== files.f ====
source/RsDecodePkg.sv
source/RsDecodeDpRam.sv
source/RsDecodeDelay.sv
source/RsSymbolFeed.sv
source/RsSyndromeCell.sv
source/RsSyndromeCollect.sv
source/RsDecodeFront.sv
test/RsDecodeFrontTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the RS decoder front end testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module RsDecodeFrontTb \
   && ./obj_dir/VRsDecodeFrontTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q -F '*** PASSED ***' sim.log \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

// ==== source/RsDecodeDelay.sv ====
// delays raw received words by delayLength enable strobes so later stages meet them with syndromes
`timescale 1ns/1ns

module RsDecodeDelay
   import RsDecodePkg::*;
#(
   parameter int delayLength = 32
) (
   input  logic    CLK,
   input  logic    RESET,
   input  logic    enable,     // one pulse per word
   input  rsWord_t dataIn,
   output rsWord_t dataOut     // word from delayLength enables ago
);

   localparam int pointerWidth = $clog2(delayLength);

   // ------------------------------------------------------------------------
   // circular pointer
   // ------------------------------------------------------------------------
   logic [pointerWidth-1:0] slotPointer;   // shared by read and write side
   rsWord_t                 ramData;

   // advance only on enable, wrap at the last slot
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         slotPointer <= '0;
      end else if (enable) begin
         if (slotPointer == pointerWidth'(delayLength - 1)) begin
            slotPointer <= '0;
         end else begin
            slotPointer <= slotPointer + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // RAM, read and write the same slot
   // ------------------------------------------------------------------------
   // the read sees what was stored one full lap earlier
   RsDecodeDpRam #(
      .depth(delayLength)
   ) delayRam (
      .CLK         (CLK),
      .writeEnable (enable),
      .writeAddress(slotPointer),
      .writeData   (dataIn),
      .readEnable  (enable),        // output moves only on enabled edges
      .readAddress (slotPointer),
      .readData    (ramData)
   );

   assign dataOut.raw = ramData.raw;   // no decoding here

endmodule

// ==== source/RsDecodeDpRam.sv ====
// simple dual-port RAM for the decoder delay line, registered read returning old data on collision
`timescale 1ns/1ns

module RsDecodeDpRam
   import RsDecodePkg::*;
#(
   parameter int depth = 32
) (
   input  logic                     CLK,
   input  logic                     writeEnable,
   input  logic [$clog2(depth)-1:0] writeAddress,
   input  rsWord_t                  writeData,
   input  logic                     readEnable,
   input  logic [$clog2(depth)-1:0] readAddress,
   output rsWord_t                  readData
);

   // ------------------------------------------------------------------------
   // storage array, raw words only
   // ------------------------------------------------------------------------
   logic [wordWidth-1:0] memory [depth];

   // write port
   always_ff @(posedge CLK) begin
      if (writeEnable) begin
         memory[writeAddress] <= writeData.raw;
      end
   end

   // read port, held while readEnable is low
   // nonblocking semantics give the pre-write value on a same-address access
   always_ff @(posedge CLK) begin
      if (readEnable) begin
         readData.raw <= memory[readAddress];
      end
   end

endmodule

// ==== source/RsDecodeFront.sv ====
// RS decoder front end top level, syndromes and delayed data for the later correction stages
`timescale 1ns/1ns

module RsDecodeFront
   import RsDecodePkg::*;
#(
   parameter int codeLength   = 32,
   parameter int numSyndromes = 8
) (
   input  logic                                CLK,
   input  logic                                RESET,
   input  logic                                enable,          // one pulse per word
   input  rsWord_t                             dataIn,
   output rsWord_t                             dataOut,         // delayed by one codeword
   output logic                                syndromeValid,
   output logic                                errorDetected,
   output logic [7:0]                          erasureCount,
   output logic [numSyndromes*symbolWidth-1:0] syndromes
);

   // one codeword of delay, data lines up with its syndromes
   localparam int delayLength = codeLength;

   // feed broadcast
   logic                                symbolStrobe;
   logic                                firstSymbol;
   logic                                lastSymbol;
   logic [symbolWidth-1:0]              symbol;
   logic [7:0]                          codewordErasures;
   logic [numSyndromes*symbolWidth-1:0] cellSyndromes;   // flat, one slice per cell

   // ------------------------------------------------------------------------
   // raw word delay line
   // ------------------------------------------------------------------------
   RsDecodeDelay #(
      .delayLength(delayLength)
   ) delayLine (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .dataIn (dataIn),
      .dataOut(dataOut)
   );

   // ------------------------------------------------------------------------
   // framing and symbol broadcast
   // ------------------------------------------------------------------------
   RsSymbolFeed #(
      .codeLength(codeLength)
   ) symbolFeed (
      .CLK             (CLK),
      .RESET           (RESET),
      .enable          (enable),
      .dataIn          (dataIn),
      .symbolStrobe    (symbolStrobe),
      .firstSymbol     (firstSymbol),
      .lastSymbol      (lastSymbol),
      .symbol          (symbol),
      .codewordErasures(codewordErasures)
   );

   // ------------------------------------------------------------------------
   // syndrome cells, roots alpha^1 .. alpha^numSyndromes
   // ------------------------------------------------------------------------
   for (genvar cellIndex = 0; cellIndex < numSyndromes; cellIndex++) begin : cellGen
      RsSyndromeCell #(
         .rootIndex(cellIndex + 1)        // first consecutive root is alpha^1
      ) syndromeCell (
         .CLK         (CLK),
         .RESET       (RESET),
         .symbolStrobe(symbolStrobe),
         .firstSymbol (firstSymbol),
         .symbol      (symbol),
         .syndrome    (cellSyndromes[cellIndex*symbolWidth +: symbolWidth])
      );
   end

   // ------------------------------------------------------------------------
   // result collection
   // ------------------------------------------------------------------------
   RsSyndromeCollect #(
      .numSyndromes(numSyndromes)
   ) syndromeCollect (
      .CLK             (CLK),
      .RESET           (RESET),
      .lastSymbol      (lastSymbol),
      .symbolStrobe    (symbolStrobe),
      .codewordErasures(codewordErasures),
      .cellSyndromes   (cellSyndromes),
      .syndromeValid   (syndromeValid),
      .errorDetected   (errorDetected),
      .erasureCount    (erasureCount),
      .syndromes       (syndromes)
   );

endmodule

// ==== source/RsDecodePkg.sv ====
// shared widths, received word layout and GF(2^8) arithmetic for the RS decoder front end

package RsDecodePkg;

   // ------------------------------------------------------------------------
   // widths and field definition
   // ------------------------------------------------------------------------
   localparam int symbolWidth = 8;                      // one GF(2^8) symbol
   localparam int wordWidth   = 9;                      // erasure flag + symbol
   localparam logic [symbolWidth-1:0] gfPoly = 8'h1D;   // x^8+x^4+x^3+x^2+1, top bit implied

   // received word, raw for storage, fields for decoding
   typedef union packed {
      logic [wordWidth-1:0] raw;
      struct packed {
         logic                   erasure;   // bit 8, symbol unreliable
         logic [symbolWidth-1:0] symbol;    // bits 7..0
      } fields;
   } rsWord_t;

   // ------------------------------------------------------------------------
   // GF(2^8) arithmetic
   // ------------------------------------------------------------------------
   // shift-and-add multiply, reduced modulo the field polynomial
   function automatic logic [symbolWidth-1:0] gfMultiply(
      input logic [symbolWidth-1:0] a,
      input logic [symbolWidth-1:0] b
   );
      logic [symbolWidth-1:0] product;
      logic [symbolWidth-1:0] shifted;
      product = '0;
      shifted = a;
      for (int bitIndex = 0; bitIndex < symbolWidth; bitIndex++) begin
         if (b[bitIndex]) product = product ^ shifted;   // add a*x^bitIndex
         // multiply by x, fold back the overflow term
         shifted = shifted[symbolWidth-1] ? ({shifted[symbolWidth-2:0], 1'b0} ^ gfPoly)
                                          : {shifted[symbolWidth-2:0], 1'b0};
      end
      return product;
   endfunction

   // alpha^power, alpha = x, group order 255
   function automatic logic [symbolWidth-1:0] gfAlphaPower(input int unsigned power);
      logic [symbolWidth-1:0] result;
      result = 8'h01;
      for (int step = 0; step < int'(power % 255); step++) begin
         result = gfMultiply(result, 8'h02);
      end
      return result;
   endfunction

endpackage

// ==== source/RsSymbolFeed.sv ====
// frames received words into codewords and broadcasts masked symbols to the syndrome cells
`timescale 1ns/1ns

module RsSymbolFeed
   import RsDecodePkg::*;
#(
   parameter int codeLength = 32
) (
   input  logic                   CLK,
   input  logic                   RESET,
   input  logic                   enable,
   input  rsWord_t                dataIn,
   output logic                   symbolStrobe,       // one cycle per accepted word
   output logic                   firstSymbol,        // highest-degree position
   output logic                   lastSymbol,         // constant-term position
   output logic [symbolWidth-1:0] symbol,             // zero when erased
   output logic [7:0]             codewordErasures    // complete with lastSymbol
);

   localparam int positionWidth = (codeLength > 1) ? $clog2(codeLength) : 1;

   // ------------------------------------------------------------------------
   // position counter
   // ------------------------------------------------------------------------
   logic [positionWidth-1:0] position;     // 0 .. codeLength-1
   logic                     atFirst;
   logic                     atLast;

   assign atFirst = (position == '0);
   assign atLast  = (position == positionWidth'(codeLength - 1));

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         position <= '0;                   // next enable opens a codeword
      end else if (enable) begin
         position <= atLast ? '0 : position + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // strobe and markers
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         symbolStrobe <= 1'b0;
         firstSymbol  <= 1'b0;
         lastSymbol   <= 1'b0;
      end else begin
         symbolStrobe <= enable;           // drops on idle cycles
         if (enable) begin
            firstSymbol <= atFirst;        // markers hold while idle
            lastSymbol  <= atLast;
         end
      end
   end

   // erased symbol counts as zero in the syndromes
   always_ff @(posedge CLK) begin
      if (enable) begin
         symbol <= dataIn.fields.erasure ? '0 : dataIn.fields.symbol;
      end
   end

   // ------------------------------------------------------------------------
   // erasure count
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         codewordErasures <= '0;
      end else if (enable) begin
         if (atFirst) begin
            codewordErasures <= 8'(dataIn.fields.erasure);   // restart per codeword
         end else begin
            codewordErasures <= codewordErasures + 8'(dataIn.fields.erasure);
         end
      end
   end

endmodule

// ==== source/RsSyndromeCell.sv ====
// one Horner accumulator evaluating the received polynomial at alpha^rootIndex
`timescale 1ns/1ns

module RsSyndromeCell
   import RsDecodePkg::*;
#(
   parameter int rootIndex = 1
) (
   input  logic                   CLK,
   input  logic                   RESET,
   input  logic                   symbolStrobe,
   input  logic                   firstSymbol,
   input  logic [symbolWidth-1:0] symbol,
   output logic [symbolWidth-1:0] syndrome     // stable between strobes
);

   // root constant, folded at elaboration
   localparam logic [symbolWidth-1:0] rootValue = gfAlphaPower(rootIndex);

   // ------------------------------------------------------------------------
   // Horner step
   // ------------------------------------------------------------------------
   logic [symbolWidth-1:0] scaled;   // accumulator * alpha^rootIndex

   // constant multiplier, reduces to an XOR network
   assign scaled = gfMultiply(syndrome, rootValue);

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         syndrome <= '0;
      end else if (symbolStrobe) begin
         if (firstSymbol) begin
            syndrome <= symbol;              // start of codeword
         end else begin
            syndrome <= scaled ^ symbol;     // addition in GF(2^8) is XOR
         end
      end
   end

endmodule

// ==== source/RsSyndromeCollect.sv ====
// latches all syndromes at codeword end, flags errors and reports the erasure count
`timescale 1ns/1ns

module RsSyndromeCollect
   import RsDecodePkg::*;
#(
   parameter int numSyndromes = 8
) (
   input  logic                                CLK,
   input  logic                                RESET,
   input  logic                                lastSymbol,
   input  logic                                symbolStrobe,
   input  logic [7:0]                          codewordErasures,
   input  logic [numSyndromes*symbolWidth-1:0] cellSyndromes,
   output logic                                syndromeValid,    // one-cycle pulse
   output logic                                errorDetected,    // held until next pulse
   output logic [7:0]                          erasureCount,
   output logic [numSyndromes*symbolWidth-1:0] syndromes         // slice j-1 is S_j
);

   // ------------------------------------------------------------------------
   // align with the cells' last update
   // ------------------------------------------------------------------------
   logic       lastDelayed;       // cells finish one edge after the feed
   logic [7:0] erasuresDelayed;

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         lastDelayed <= 1'b0;
      end else begin
         lastDelayed <= symbolStrobe & lastSymbol;
      end
   end

   always_ff @(posedge CLK) begin
      erasuresDelayed <= codewordErasures;   // only sampled with lastDelayed
   end

   // ------------------------------------------------------------------------
   // result latch
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         syndromeValid <= 1'b0;
         errorDetected <= 1'b0;
         erasureCount  <= '0;
         syndromes     <= '0;
      end else begin
         syndromeValid <= lastDelayed;       // self-clearing
         if (lastDelayed) begin
            syndromes     <= cellSyndromes;
            errorDetected <= |cellSyndromes;  // any nonzero S_j
            erasureCount  <= erasuresDelayed;
         end
      end
   end

endmodule

// ==== test/RsDecodeFrontTb.sv ====
// self-checking testbench for the RS decoder front end that files.f lists and run.sh runs
`timescale 1ns/1ns

module RsDecodeFrontTb
   import RsDecodePkg::*;
();

   localparam int codeLength    = 32;
   localparam int numSyndromes  = 8;
   localparam int delayLength   = codeLength;
   localparam int messageLength = codeLength - numSyndromes;   // 24 data symbols
   localparam int fullCodewords = 16;
   localparam int numCodewords  = fullCodewords + 1;           // plus the one cut by reset
   localparam int timeoutCycles = numCodewords * codeLength * 2 + 100;
   localparam int kindClean     = 0;
   localparam int kindErrors    = 1;
   localparam int kindErasures  = 2;

   logic                                CLK;
   logic                                RESET;
   logic                                enable;
   rsWord_t                             dataIn;
   rsWord_t                             dataOut;
   logic                                syndromeValid;
   logic                                errorDetected;
   logic [7:0]                          erasureCount;
   logic [numSyndromes*symbolWidth-1:0] syndromes;

   logic [31:0]            randomState = 32'd48;    // xorshift seed
   logic [symbolWidth-1:0] generator [numSyndromes+1];   // g(x) coefficients by degree
   logic [symbolWidth-1:0] codeword [codeLength];        // highest degree first
   rsWord_t                receivedWords [codeLength];

   // word scoreboard and per-codeword expected results
   rsWord_t                             sentWords [$];
   logic [numSyndromes*symbolWidth-1:0] expSyndromes [$];
   logic                                expError [$];
   logic [7:0]                          expErasures [$];

   int   cycleCount    = 0;      // rising edges seen
   int   lastEdgeCycle = 0;      // edge of the most recent last symbol
   int   framePosition = 0;
   logic inReset       = 1'b0;   // RESET as seen at the last rising edge
   logic pulseSeen     = 1'b0;

   RsDecodeFront dut0 (
      .CLK          (CLK),
      .RESET        (RESET),
      .enable       (enable),
      .dataIn       (dataIn),
      .dataOut      (dataOut),
      .syndromeValid(syndromeValid),
      .errorDetected(errorDetected),
      .erasureCount (erasureCount),
      .syndromes    (syndromes)
   );

   always #50 CLK = ~CLK;   // 100 ns period

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshiftNext();
      logic [31:0] x;
      x = randomState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      randomState = x;
      return x;
   endfunction

   task automatic stopRun();
      $display("*** FAILED ***");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic compareValue(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
      assert (actual === expected) else begin
         $display("[ERROR] %0t %s is %0h, expected %0h", $time, name, actual, expected);
         stopRun();
      end
   endtask

   // g(x) = (x + a^1)(x + a^2)...(x + a^8)
   task automatic buildGenerator();
      logic [symbolWidth-1:0] root;
      for (int i = 0; i <= numSyndromes; i++) begin
         generator[i] = (i == 0) ? 8'h01 : 8'h00;
      end
      for (int j = 1; j <= numSyndromes; j++) begin
         root = gfAlphaPower(unsigned'(j));
         for (int i = numSyndromes; i > 0; i--) begin   // descending keeps old terms
            generator[i] = generator[i-1] ^ gfMultiply(generator[i], root);
         end
         generator[0] = gfMultiply(generator[0], root);
      end
   endtask

   // systematic encoder by LFSR division through g(x)
   task automatic encodeCodeword();
      logic [symbolWidth-1:0] parity [numSyndromes];
      logic [symbolWidth-1:0] feedback;
      for (int i = 0; i < numSyndromes; i++) begin
         parity[i] = '0;
      end
      for (int pos = 0; pos < messageLength; pos++) begin
         codeword[pos] = 8'(xorshiftNext());
         feedback      = codeword[pos] ^ parity[numSyndromes-1];
         for (int i = numSyndromes - 1; i > 0; i--) begin
            parity[i] = parity[i-1] ^ gfMultiply(feedback, generator[i]);
         end
         parity[0] = gfMultiply(feedback, generator[0]);
      end
      for (int i = 0; i < numSyndromes; i++) begin
         codeword[messageLength + i] = parity[numSyndromes-1-i];   // remainder high term first
      end
   endtask

   // Horner evaluation at a^1..a^8 with erased symbols as zero
   function automatic logic [numSyndromes*symbolWidth-1:0] referenceSyndromes();
      logic [numSyndromes*symbolWidth-1:0] result;
      logic [symbolWidth-1:0]              acc;
      logic [symbolWidth-1:0]              root;
      logic [symbolWidth-1:0]              value;
      result = '0;
      for (int j = 1; j <= numSyndromes; j++) begin
         root = gfAlphaPower(unsigned'(j));
         acc  = '0;
         for (int pos = 0; pos < codeLength; pos++) begin
            value = receivedWords[pos].fields.erasure ? 8'h00 : receivedWords[pos].fields.symbol;
            acc   = gfMultiply(acc, root) ^ value;
         end
         result[(j-1)*symbolWidth +: symbolWidth] = acc;
      end
      return result;
   endfunction

   // ------------------------------------------------------------------------
   // stimulus tasks entered just after a falling edge
   // ------------------------------------------------------------------------
   task automatic applyReset();
      RESET = 1'b0;
      repeat (2) begin
         @(negedge CLK);
      end
      RESET = 1'b1;
   endtask

   task automatic sendWord(input rsWord_t word, input int gap);
      enable = 1'b1;
      dataIn = word;
      @(negedge CLK);
      enable     = 1'b0;
      dataIn.raw = wordWidth'(xorshiftNext());   // junk on idle cycles
      for (int i = 0; i < gap; i++) begin
         @(negedge CLK);
      end
   endtask

   task automatic sendCodeword(input int kind, input bit useGaps, input int symbolsToSend);
      int                                  firstPos;
      int                                  count;
      int                                  slot;
      logic [numSyndromes*symbolWidth-1:0] reference;
      encodeCodeword();
      for (int pos = 0; pos < codeLength; pos++) begin
         receivedWords[pos].raw = {1'b0, codeword[pos]};
      end
      firstPos = int'(xorshiftNext() % codeLength);
      count    = 0;
      if (kind == kindErrors) begin
         count = int'(xorshiftNext() % 3) + 1;        // distinct slots 11 apart
         for (int i = 0; i < count; i++) begin
            slot = (firstPos + 11 * i) % codeLength;
            receivedWords[slot].fields.symbol ^= 8'(xorshiftNext() % 255 + 1);
         end
      end else if (kind == kindErasures) begin
         count = int'(xorshiftNext() % 4) + 1;        // 7 apart
         for (int i = 0; i < count; i++) begin
            slot = (firstPos + 7 * i) % codeLength;
            receivedWords[slot].fields.erasure = 1'b1;
            receivedWords[slot].fields.symbol  = 8'(xorshiftNext());   // must be masked
         end
      end
      reference = referenceSyndromes();
      if (symbolsToSend == codeLength) begin          // cut codewords expect no result
         expSyndromes.push_back((kind == kindClean) ? '0 : reference);
         expError.push_back((kind == kindClean) ? 1'b0 :
                            (kind == kindErrors) ? 1'b1 : |reference);
         expErasures.push_back((kind == kindErasures) ? 8'(count) : 8'd0);
      end
      for (int pos = 0; pos < symbolsToSend; pos++) begin
         sendWord(receivedWords[pos], useGaps ? int'(xorshiftNext() % 2) : 0);
      end
   endtask

   // ------------------------------------------------------------------------
   // monitor on rising edges and checks on falling edges
   // ------------------------------------------------------------------------
   always @(posedge CLK) begin
      cycleCount = cycleCount + 1;
      inReset    = !RESET;
      if (!RESET) begin
         sentWords.delete();                          // delay pointer restarts
         framePosition = 0;
      end else if (enable) begin
         sentWords.push_back(dataIn);
         if (framePosition == codeLength - 1) begin
            lastEdgeCycle = cycleCount;
            framePosition = 0;
         end else begin
            framePosition = framePosition + 1;
         end
      end
   end

   always @(negedge CLK) begin
      logic [numSyndromes*symbolWidth-1:0] wantSyndromes;
      logic                                wantError;
      logic [7:0]                          wantErasures;
      if (inReset) begin
         pulseSeen = 1'b0;
         compareValue("syndromeValid", 64'(syndromeValid), 64'd0);
         compareValue("errorDetected", 64'(errorDetected), 64'd0);
         compareValue("erasureCount", 64'(erasureCount), 64'd0);
         compareValue("syndromes", 64'(syndromes), 64'd0);
      end else if (!pulseSeen) begin
         compareValue("errorDetected", 64'(errorDetected), 64'd0);
      end
      if (sentWords.size() > delayLength) begin       // output holds between enables
         compareValue("dataOut", 64'(dataOut.raw),
                      64'(sentWords[sentWords.size() - 1 - delayLength].raw));
      end
      if (syndromeValid && !inReset) begin
         if (expSyndromes.size() == 0) begin
            $display("syndromeValid pulsed at %0t with no codeword outstanding", $time);
            stopRun();
         end else begin
            wantSyndromes = expSyndromes.pop_front();
            wantError     = expError.pop_front();
            wantErasures  = expErasures.pop_front();
            compareValue("syndromeValid latency", 64'(cycleCount - lastEdgeCycle), 64'd2);
            compareValue("syndromes", 64'(syndromes), 64'(wantSyndromes));
            compareValue("errorDetected", 64'(errorDetected), 64'(wantError));
            compareValue("erasureCount", 64'(erasureCount), 64'(wantErasures));
            pulseSeen = 1'b1;
         end
      end
   end

   initial begin
      #(timeoutCycles * 100);
      $display("watchdog expired after %0d clock periods, run did not complete", timeoutCycles);
      stopRun();
   end

   initial begin
      CLK        = 1'b0;
      RESET      = 1'b0;
      enable     = 1'b0;
      dataIn.raw = '0;
      buildGenerator();
      applyReset();
      for (int i = 0; i < 3; i++) begin
         sendCodeword(kindClean, 1'b0, codeLength);   // back-to-back
      end
      for (int i = 0; i < 3; i++) begin
         sendCodeword(kindClean, 1'b1, codeLength);   // random idle gaps
      end
      for (int i = 0; i < 4; i++) begin
         sendCodeword(kindErrors, (i % 2) == 1, codeLength);
      end
      for (int i = 0; i < 3; i++) begin
         sendCodeword(kindErasures, 1'b1, codeLength);
      end
      sendCodeword(kindClean, 1'b0, codeLength / 2);  // cut off by reset
      applyReset();
      for (int i = 0; i < 2; i++) begin
         sendCodeword(kindClean, 1'b0, codeLength);
      end
      sendCodeword(kindErrors, 1'b1, codeLength);
      while (expSyndromes.size() != 0) begin
         @(negedge CLK);
      end
      repeat (4) begin
         @(negedge CLK);
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule
